// File: hdl/tlp_pkg.sv
// TLP handler shared types
// Avalon-ST beat, decoded frame record, memory-access request and response,
// TLP kind and completion status enums, plus completion header encodings.
`default_nettype none

package tlp_pkg;

  // One 256-bit Avalon-ST beat, dword 0 is the first header dword
  typedef struct packed {
    logic [7:0][31:0] data;
    logic [2:0]       empty;          // Unused dwords at the end
    logic             startofpacket;
    logic             endofpacket;
    logic             valid;
  } tlp_stream_t;

  // Decoded from {fmt[1], type}
  typedef enum logic [2:0] {
    TLP_MRD,
    TLP_MRDLK,
    TLP_MWR,
    TLP_CPL,
    TLP_CPLD,
    TLP_UNKNOWN
  } tlp_kind_e;

  typedef enum logic [2:0] {
    CPL_SC = 3'd0,  // Successful completion
    CPL_UR = 3'd1   // Unsupported request
  } cpl_status_e;

  typedef struct packed {
    tlp_kind_e   kind;
    logic [15:0] requester_id;
    logic [7:0]  tag;
    logic [3:0]  first_be;
    logic [31:0] address;       // Dword aligned
    logic [31:0] data;          // Single write dword
    logic [9:0]  len;
    logic [11:0] byte_count;    // From length and BEs
    logic        is_npr;        // Needs a completion
    logic        is_pr;
    logic        is_4dw;
    logic        unsupported;
  } tlp_frame_t;

  typedef struct packed {
    logic        is_write;
    logic [15:0] requester_id;
    logic [7:0]  tag;
    logic [31:0] data;
    logic [29:0] dword_addr;    // Region relative
  } mem_req_t;

  typedef struct packed {
    logic [15:0] requester_id;
    logic [7:0]  tag;
    logic [4:0]  lower_addr_dw;
    logic [31:0] rddata;
  } mem_resp_t;

  // {fmt[1], type} of the request kinds we tell apart
  localparam logic [5:0] RAW_MRD   = 6'b000000;
  localparam logic [5:0] RAW_MRDLK = 6'b000001;
  localparam logic [5:0] RAW_MWR   = 6'b100000;
  localparam logic [5:0] RAW_CPL   = 6'b001010;
  localparam logic [5:0] RAW_CPLD  = 6'b101010;

  localparam logic [2:0] CPL_FMT_NODATA = 3'b000;
  localparam logic [2:0] CPL_FMT_DATA   = 3'b010;
  localparam logic [4:0] CPL_TYPE       = 5'b01010;

  // cpl_err bits toward the hard IP
  localparam int CPL_ERR_UR_P  = 4;  // UR on posted TLP
  localparam int CPL_ERR_UR_NP = 5;  // UR on non-posted TLP

  // Three header dwords of a completion
  function automatic logic [2:0][31:0] cpl_header(
    input logic [2:0]  fmt,
    input logic [9:0]  len,
    input logic [15:0] completer_id,
    input cpl_status_e status,
    input logic [11:0] byte_count,
    input logic [15:0] requester_id,
    input logic [7:0]  tag,
    input logic [6:0]  lower_addr
  );
    logic [2:0][31:0] hdr;
    hdr = '0;
    hdr[0][31:29] = fmt;
    hdr[0][28:24] = CPL_TYPE;
    hdr[0][9:0]   = len;
    hdr[1][31:16] = completer_id;
    hdr[1][15:13] = status;
    hdr[1][11:0]  = byte_count;
    hdr[2][31:16] = requester_id;
    hdr[2][15:8]  = tag;
    hdr[2][6:0]   = lower_addr;
    return hdr;
  endfunction

endpackage

`default_nettype wire

// File: hdl/tlp_rx_decoder.sv
// TLP receive decoder
// Turns a start-of-packet beat into a registered frame record: kind, header
// fields, write data, posted/non-posted class, byte count and the
// unsupported-request verdict. Pulses frame_start and frame_end.
`default_nettype none

module tlp_rx_decoder
  import tlp_pkg::*;
(
  input  wire              clk,
  input  wire              reset,
  input  wire              enable,
  input  wire tlp_stream_t rx,
  output tlp_frame_t       frame,
  output logic             frame_start,
  output logic             frame_end
);

  logic [2:0]  fmt;
  logic [4:0]  raw_type;
  logic [5:0]  raw_kind;
  logic        take_sop;
  tlp_frame_t  next_frame;

  // Index of lowest enabled byte
  function automatic logic [1:0] lowest_set(input logic [3:0] be);
    casez (be)
      4'b???1: return 2'd0;
      4'b??10: return 2'd1;
      4'b?100: return 2'd2;
      default: return 2'd3;
    endcase
  endfunction

  // Index of highest enabled byte
  function automatic logic [1:0] highest_set(input logic [3:0] be);
    casez (be)
      4'b1???: return 2'd3;
      4'b01??: return 2'd2;
      4'b001?: return 2'd1;
      default: return 2'd0;
    endcase
  endfunction

  // Byte count from length and BEs, as in the PCIe base spec table
  function automatic logic [11:0] calc_byte_count(
    input logic [9:0] len,
    input logic [3:0] first_be,
    input logic [3:0] last_be
  );
    logic [11:0] full;
    full = {len, 2'b00};
    if (first_be == 4'b0000) begin
      return 12'd0;  // Zero-length read, or bogus BEs
    end
    if (last_be == 4'b0000) begin
      // Single dword, span of first BE
      return 12'(highest_set(first_be)) - 12'(lowest_set(first_be)) + 12'd1;
    end
    return full - 12'(lowest_set(first_be)) - 12'(2'd3 - highest_set(last_be));
  endfunction

  assign fmt      = rx.data[0][31:29];
  assign raw_type = rx.data[0][28:24];
  assign raw_kind = {fmt[1], raw_type};
  assign take_sop = enable && rx.valid && rx.startofpacket;

  always_comb begin
    next_frame = '0;
    case (raw_kind)
      RAW_MRD:   next_frame.kind = TLP_MRD;
      RAW_MRDLK: next_frame.kind = TLP_MRDLK;
      RAW_MWR:   next_frame.kind = TLP_MWR;
      RAW_CPL:   next_frame.kind = TLP_CPL;
      RAW_CPLD:  next_frame.kind = TLP_CPLD;
      default:   next_frame.kind = TLP_UNKNOWN;
    endcase

    // Non-posted needs a completion, posted does not
    casez (raw_kind)
      6'b00000?: next_frame.is_npr = 1'b1;  // MRd, MRdLk
      6'b?00010: next_frame.is_npr = 1'b1;  // IORd, IOWr
      6'b1011??: next_frame.is_npr = 1'b1;  // AtomicOp
      6'b100000: next_frame.is_pr  = 1'b1;  // MWr
      6'b?10???: next_frame.is_pr  = 1'b1;  // Msg, MsgD
      default: ;
    endcase

    next_frame.is_4dw       = fmt[0];
    next_frame.len          = rx.data[0][9:0];
    next_frame.requester_id = rx.data[1][31:16];
    next_frame.tag          = rx.data[1][15:8];
    next_frame.first_be     = rx.data[1][3:0];
    next_frame.byte_count   = calc_byte_count(rx.data[0][9:0], rx.data[1][3:0],
                                              rx.data[1][7:4]);

    if (fmt[0]) begin
      next_frame.address = {rx.data[3][31:2], 2'b00};  // Low half of 64-bit address
      next_frame.data    = rx.data[4];
    end else begin
      next_frame.address = {rx.data[2][31:2], 2'b00};
      // Hard IP pads the header when address bit 2 is clear
      next_frame.data    = rx.data[2][2] ? rx.data[3] : rx.data[4];
    end

    // Only 32-bit single dword MRd/MWr are served
    if (next_frame.kind inside {TLP_UNKNOWN, TLP_CPL, TLP_MRDLK}) begin
      next_frame.unsupported = 1'b1;
    end else if (next_frame.is_4dw) begin
      next_frame.unsupported = 1'b1;  // No 64-bit addressing
    end else if (next_frame.kind inside {TLP_MRD, TLP_MWR}) begin
      next_frame.unsupported = (next_frame.len != 10'd1) ||
                               (next_frame.byte_count != 12'd0 &&
                                next_frame.byte_count != 12'd4);
    end
  end

  // Frame record holds until the next SOP
  always_ff @(posedge clk) begin
    if (take_sop) begin
      frame <= next_frame;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      frame_start <= 1'b0;
      frame_end   <= 1'b0;
    end else begin
      frame_start <= take_sop;
      frame_end   <= enable && rx.valid && rx.endofpacket;  // Registered EOP
    end
  end

endmodule

`default_nettype wire

// File: hdl/tlp_request_router.sv
// TLP request router
// Sends finished supported MRd/MWr frames to the memory-access port, emits
// UR and zero-length-read completions on the instant stream, and raises
// the UR bits of the completion error vector.
`default_nettype none

module tlp_request_router
  import tlp_pkg::*;
#(
  parameter int REGION_ADDR_BITS = 16
) (
  input  wire              clk,
  input  wire              reset,
  input  wire              enable,
  input  wire [15:0]       completer_id,
  input  wire tlp_frame_t  frame,
  input  wire              frame_start,
  input  wire              frame_end,
  output mem_req_t         mem_req,
  output logic             mem_req_valid,
  input  wire              mem_req_ready,
  output tlp_stream_t      instant_tx,
  output logic [6:0]       cpl_err
);

  // Wraps to all ones for a full 32-bit region
  localparam logic [31:0] REGION_MASK = (32'h1 << REGION_ADDR_BITS) - 32'h1;

  logic [31:0]      masked_addr;
  logic             is_mem_kind;
  logic             issue_req;
  logic             issue_cpl;
  logic [2:0]       cpl_fmt;
  cpl_status_e      cpl_status;
  logic [11:0]      cpl_bytes;
  logic [2:0][31:0] cpl_hdr;

  assign masked_addr = frame.address & REGION_MASK;
  assign is_mem_kind = (frame.kind == TLP_MRD) || (frame.kind == TLP_MWR);
  // Zero-length accesses never reach memory
  assign issue_req   = enable && frame_end && !frame.unsupported && is_mem_kind &&
                       (frame.byte_count != 12'd0);
  assign issue_cpl   = enable && frame_end && frame.is_npr &&
                       (frame.unsupported || frame.byte_count == 12'd0);

  always_comb begin
    if (frame.unsupported) begin
      cpl_fmt    = CPL_FMT_NODATA;
      cpl_status = CPL_UR;
      cpl_bytes  = frame.byte_count;
    end else begin
      cpl_fmt    = CPL_FMT_DATA;  // CplD with nothing in it
      cpl_status = CPL_SC;
      cpl_bytes  = 12'd0;
    end
    cpl_hdr = cpl_header(cpl_fmt, 10'd0, completer_id, cpl_status, cpl_bytes,
                         frame.requester_id, frame.tag, frame.address[6:0]);
  end

  always_ff @(posedge clk) begin
    if (issue_req) begin
      mem_req.is_write     <= (frame.kind == TLP_MWR);
      mem_req.requester_id <= frame.requester_id;
      mem_req.tag          <= frame.tag;
      mem_req.data         <= (frame.kind == TLP_MWR) ? frame.data : 32'h0;
      mem_req.dword_addr   <= masked_addr[31:2];
    end
    if (issue_cpl) begin
      instant_tx.data      <= {160'h0, cpl_hdr};  // 3DW header only
      instant_tx.empty     <= 3'd5;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      mem_req_valid            <= 1'b0;
      instant_tx.valid         <= 1'b0;
      instant_tx.startofpacket <= 1'b0;
      instant_tx.endofpacket   <= 1'b0;
    end else begin
      mem_req_valid            <= issue_req;
      instant_tx.valid         <= issue_cpl;  // Single beat TLP
      instant_tx.startofpacket <= issue_cpl;
      instant_tx.endofpacket   <= issue_cpl;
    end
  end

  // UR errors go out as soon as the frame is known
  always_comb begin
    cpl_err                = '0;
    cpl_err[CPL_ERR_UR_P]  = frame_start && frame.unsupported && frame.is_pr;
    cpl_err[CPL_ERR_UR_NP] = frame_start && frame.unsupported && frame.is_npr;
  end

  // Memory side must keep up, requests are never held
  a_req_accepted: assert property (@(posedge clk) disable iff (reset)
    mem_req_valid |-> mem_req_ready);

endmodule

`default_nettype wire

// File: hdl/completion_builder.sv
// Successful completion builder
// Wraps each memory read response into a one-dword CplD on the response
// stream, placing the data dword to match the lower address alignment.
`default_nettype none

module completion_builder
  import tlp_pkg::*;
(
  input  wire             clk,
  input  wire             reset,
  input  wire             enable,
  input  wire [15:0]      completer_id,
  input  wire mem_resp_t  mem_resp,
  input  wire             mem_resp_valid,
  output tlp_stream_t     response_tx
);

  logic             take_resp;
  logic [6:0]       lower_addr;
  logic [7:0][31:0] cpl_dw;

  assign take_resp  = enable && mem_resp_valid;
  assign lower_addr = {mem_resp.lower_addr_dw, 2'b00};

  always_comb begin
    cpl_dw      = '0;
    cpl_dw[2:0] = cpl_header(CPL_FMT_DATA, 10'd1, completer_id, CPL_SC, 12'd4,
                             mem_resp.requester_id, mem_resp.tag, lower_addr);
    if (!lower_addr[2]) begin
      cpl_dw[4] = mem_resp.rddata;  // Qword aligned, header padded
    end else begin
      cpl_dw[3] = mem_resp.rddata;
    end
  end

  always_ff @(posedge clk) begin
    if (take_resp) begin
      response_tx.data  <= cpl_dw;
      response_tx.empty <= lower_addr[2] ? 3'd4 : 3'd3;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      response_tx.valid         <= 1'b0;
      response_tx.startofpacket <= 1'b0;
      response_tx.endofpacket   <= 1'b0;
    end else begin
      response_tx.valid         <= take_resp;
      response_tx.startofpacket <= take_resp;
      response_tx.endofpacket   <= take_resp;
    end
  end

  // Memory side answers only while mem_resp_ready is high
  a_resp_taken: assert property (@(posedge clk) disable iff (reset)
    mem_resp_valid |-> enable);

endmodule

`default_nettype wire

// File: hdl/tlp_stats_csr.sv
// TLP statistics and CSR read port
// Counts received, unsupported, instant and response TLPs and returns
// them, together with the completer ID status, on CSR reads.
`default_nettype none

module tlp_stats_csr
  import tlp_pkg::*;
#(
  parameter int STAT_WIDTH = 32
) (
  input  wire              clk,
  input  wire              reset,
  input  wire tlp_stream_t rx,
  input  wire              rx_ready,
  input  wire              frame_end,
  input  wire              frame_unsupported,
  input  wire tlp_stream_t instant_tx,
  input  wire tlp_stream_t response_tx,
  input  wire [15:0]       completer_id,
  input  wire              completer_id_valid,
  input  wire              csr_read,
  input  wire [5:0]        csr_address,
  output logic [31:0]      csr_readdata
);

  localparam int CNT_RX    = 0;
  localparam int CNT_UNSUP = 1;
  localparam int CNT_INST  = 2;
  localparam int CNT_RESP  = 3;

  logic [3:0]            inc;
  logic [STAT_WIDTH-1:0] cnt [4];

  assign inc[CNT_RX]    = rx_ready && rx.valid && rx.startofpacket;
  assign inc[CNT_UNSUP] = frame_end && frame_unsupported;
  assign inc[CNT_INST]  = instant_tx.valid && instant_tx.startofpacket;
  assign inc[CNT_RESP]  = response_tx.valid && response_tx.startofpacket;

  always_ff @(posedge clk) begin
    for (int i = 0; i < 4; i++) begin
      if (reset) begin
        cnt[i] <= '0;
      end else if (inc[i]) begin
        cnt[i] <= cnt[i] + 1'b1;  // Wraps
      end
    end
  end

  // Read data one cycle after csr_read
  always_ff @(posedge clk) begin
    if (csr_read) begin
      case (csr_address)
        6'd0:    csr_readdata <= {15'h0, completer_id_valid, completer_id};
        6'd1:    csr_readdata <= 32'(cnt[CNT_RX]);
        6'd2:    csr_readdata <= 32'(cnt[CNT_UNSUP]);
        6'd4:    csr_readdata <= 32'(cnt[CNT_INST]);
        6'd5:    csr_readdata <= 32'(cnt[CNT_RESP]);
        default: csr_readdata <= 32'hffff_ffff;  // Unmapped
      endcase
    end
  end

endmodule

`default_nettype wire

// File: hdl/fejkon_tlp_top.sv
// Fejkon PCIe receive-side TLP handler
// Serves a small memory region behind a BAR: decodes received TLPs, routes
// memory requests, answers with completions and keeps statistics.
// Processing runs only once the completer ID is known.
`default_nettype none

module fejkon_tlp_top
  import tlp_pkg::*;
#(
  parameter int REGION_ADDR_BITS = 16,
  parameter int STAT_WIDTH       = 32
) (
  input  wire              clk,
  input  wire              reset,
  input  wire [15:0]       completer_id,
  input  wire              completer_id_valid,
  input  wire tlp_stream_t rx,
  output logic             rx_ready,
  output tlp_stream_t      instant_tx,     // UR and zero-length completions
  output tlp_stream_t      response_tx,    // Successful CplD
  output mem_req_t         mem_req,
  output logic             mem_req_valid,
  input  wire              mem_req_ready,
  input  wire mem_resp_t   mem_resp,
  input  wire              mem_resp_valid,
  output logic             mem_resp_ready,
  input  wire              csr_read,
  input  wire [5:0]        csr_address,
  output logic [31:0]      csr_readdata,
  output logic [6:0]       cpl_err
);

  logic       ready_en;
  tlp_frame_t frame;
  logic       frame_start;
  logic       frame_end;

  assign ready_en       = completer_id_valid;  // Nothing to do without an ID
  assign rx_ready       = ready_en;
  assign mem_resp_ready = ready_en;

  tlp_rx_decoder u_decoder (
    .clk         (clk),
    .reset       (reset),
    .enable      (ready_en),
    .rx          (rx),
    .frame       (frame),
    .frame_start (frame_start),
    .frame_end   (frame_end)
  );

  tlp_request_router #(
    .REGION_ADDR_BITS (REGION_ADDR_BITS)
  ) u_router (
    .clk           (clk),
    .reset         (reset),
    .enable        (ready_en),
    .completer_id  (completer_id),
    .frame         (frame),
    .frame_start   (frame_start),
    .frame_end     (frame_end),
    .mem_req       (mem_req),
    .mem_req_valid (mem_req_valid),
    .mem_req_ready (mem_req_ready),
    .instant_tx    (instant_tx),
    .cpl_err       (cpl_err)
  );

  completion_builder u_cpl_builder (
    .clk            (clk),
    .reset          (reset),
    .enable         (ready_en),
    .completer_id   (completer_id),
    .mem_resp       (mem_resp),
    .mem_resp_valid (mem_resp_valid),
    .response_tx    (response_tx)
  );

  tlp_stats_csr #(
    .STAT_WIDTH (STAT_WIDTH)
  ) u_stats (
    .clk                (clk),
    .reset              (reset),
    .rx                 (rx),
    .rx_ready           (rx_ready),
    .frame_end          (frame_end),
    .frame_unsupported  (frame.unsupported),
    .instant_tx         (instant_tx),
    .response_tx        (response_tx),
    .completer_id       (completer_id),
    .completer_id_valid (completer_id_valid),
    .csr_read           (csr_read),
    .csr_address        (csr_address),
    .csr_readdata       (csr_readdata)
  );

endmodule

`default_nettype wire

// File: tests/tb_clock.sv
// Testbench clock and reset
// 10 unit clock period, reset held high for the first 16 cycles.
`default_nettype none

module tb_clock (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    reset = 1'b1;
    repeat (16) @(posedge clk);
    #1 reset = 1'b0;  // Released just after the edge, like other inputs
  end

endmodule

`default_nettype wire

// File: tests/tlp_checker.sv
// TLP handler checker
// Collects memory requests, completions and error pulses during each test,
// compares them with the expected outcome and counts passing tests.
`default_nettype none

module tlp_checker
  import tlp_pkg::*;
(
  input  wire              clk,
  input  wire              reset,
  input  wire              test_start,
  input  wire              test_done,
  input  wire              csr_check,
  input  wire [95:0]       test_name,
  input  wire [1:0]        exp_req,      // None, read or write
  input  wire [29:0]       exp_dw_addr,
  input  wire [31:0]       exp_wdata,
  input  wire [15:0]       exp_req_id,
  input  wire [7:0]        exp_tag,
  input  wire [1:0]        exp_cpl,      // Kind of completion expected
  input  wire [11:0]       exp_bc,
  input  wire [6:0]        exp_lower,
  input  wire [31:0]       exp_rddata,
  input  wire [6:0]        exp_err,
  input  wire [31:0]       exp_csr,
  input  wire [15:0]       completer_id,
  input  wire              completer_id_valid,
  input  wire              rx_ready,
  input  wire              mem_resp_ready,
  input  wire mem_req_t    mem_req,
  input  wire              mem_req_valid,
  input  wire tlp_stream_t instant_tx,
  input  wire tlp_stream_t response_tx,
  input  wire [6:0]        cpl_err,
  input  wire [31:0]       csr_readdata,
  output int               tests_run,
  output int               tests_failed
);

  localparam logic [1:0] REQ_NONE  = 2'd0;
  localparam logic [1:0] REQ_WR    = 2'd2;
  localparam logic [1:0] EXP_UR    = 2'd1;
  localparam logic [1:0] EXP_ZERO  = 2'd2;
  localparam logic [1:0] EXP_DATA  = 2'd3;

  int          n_req;
  int          n_inst;
  int          n_resp;
  int          n_err;
  int          fails;
  mem_req_t    got_req;
  tlp_stream_t got_inst;
  tlp_stream_t got_resp;
  logic [6:0]  got_err;

  // Single beat completion as the PCIe spec lays it out
  function automatic tlp_stream_t expect_beat(input logic [2:0] fmt, input logic [9:0] len,
                                              input logic [2:0] status, input logic has_data);
    tlp_stream_t beat;
    beat = '0;
    beat.data[0] = {fmt, 5'b01010, 14'h0, len};
    beat.data[1] = {completer_id, status, 1'b0, exp_bc};
    beat.data[2] = {exp_req_id, exp_tag, 1'b0, exp_lower};
    beat.empty   = 3'd5;  // Header only
    if (has_data) begin
      if (exp_lower[2]) begin
        beat.data[3] = exp_rddata;
        beat.empty   = 3'd4;
      end else begin
        beat.data[4] = exp_rddata;  // Padded after header
        beat.empty   = 3'd3;
      end
    end
    beat.valid         = 1'b1;
    beat.startofpacket = 1'b1;
    beat.endofpacket   = 1'b1;
    return beat;
  endfunction

  task automatic compare(input string what, input logic [261:0] expv, input logic [261:0] act);
    if (expv !== act) begin
      $display("MISMATCH %0s %0s expected %h actual %h", test_name, what, expv, act);
      fails++;
    end
  endtask

  task automatic count_check(input string what, input int expn, input int got);
    if (expn != got) begin
      $display("%0s: expected %0d %0s but saw %0d", test_name, expn, what, got);
      fails++;
    end
  endtask

  // Both ready outputs follow the completer ID valid flag
  task automatic check_ready();
    compare("rx_ready", 262'(completer_id_valid), 262'(rx_ready));
    compare("mem_resp_ready", 262'(completer_id_valid), 262'(mem_resp_ready));
  endtask

  task automatic check_case();
    mem_req_t    req_e;
    tlp_stream_t beat_e;
    fails = 0;
    count_check("memory requests", (exp_req != REQ_NONE) ? 1 : 0, n_req);
    if (exp_req != REQ_NONE && n_req == 1) begin
      req_e.is_write     = (exp_req == REQ_WR);
      req_e.requester_id = exp_req_id;
      req_e.tag          = exp_tag;
      req_e.data         = (exp_req == REQ_WR) ? exp_wdata : 32'h0;
      req_e.dword_addr   = exp_dw_addr;
      compare("request", 262'(req_e), 262'(got_req));
    end
    count_check("instant completions", (exp_cpl == EXP_UR || exp_cpl == EXP_ZERO) ? 1 : 0,
                n_inst);
    if (exp_cpl == EXP_UR && n_inst == 1) begin
      beat_e = expect_beat(3'b000, 10'd0, 3'd1, 1'b0);
      compare("ur completion", beat_e, got_inst);
    end
    if (exp_cpl == EXP_ZERO && n_inst == 1) begin
      beat_e = expect_beat(3'b010, 10'd0, 3'd0, 1'b0);
      compare("zero cpld", beat_e, got_inst);
    end
    count_check("response completions", (exp_cpl == EXP_DATA) ? 1 : 0, n_resp);
    if (exp_cpl == EXP_DATA && n_resp == 1) begin
      beat_e = expect_beat(3'b010, 10'd1, 3'd0, 1'b1);
      compare("cpld", beat_e, got_resp);
    end
    count_check("cpl_err pulse cycles", (exp_err != 7'h0) ? 1 : 0, n_err);
    compare("cpl_err", 262'(exp_err), 262'(got_err));
    check_ready();
    tests_run++;
    if (fails != 0) begin
      tests_failed++;
      $display("test %0s FAILED", test_name);
    end else begin
      $display("test %0s ok", test_name);
    end
  endtask

  initial begin
    tests_run    = 0;
    tests_failed = 0;
  end

  always @(posedge clk) begin
    if (reset || test_start) begin
      n_req   = 0;
      n_inst  = 0;
      n_resp  = 0;
      n_err   = 0;
      got_err = 7'h0;
    end else begin
      if (mem_req_valid) begin
        n_req++;
        got_req = mem_req;
      end
      if (instant_tx.valid) begin
        n_inst++;
        got_inst = instant_tx;
      end
      if (response_tx.valid) begin
        n_resp++;
        got_resp = response_tx;
      end
      if (cpl_err != 7'h0) begin
        n_err++;
        got_err = got_err | cpl_err;
      end
    end
    if (test_done) check_case();
    if (csr_check) begin
      fails = 0;
      compare("csr_readdata", 262'(exp_csr), 262'(csr_readdata));
      check_ready();
      tests_run++;
      if (fails != 0) begin
        tests_failed++;
        $display("test %0s FAILED", test_name);
      end else begin
        $display("test %0s ok", test_name);
      end
    end
  end

endmodule

`default_nettype wire

// File: tests/tb_top.sv
// TLP handler testbench top
// Applies a table of TLPs, answers memory reads, then reads the CSRs.
// The checker module does all comparisons.
`default_nettype none

module tb_top
  import tlp_pkg::*;
();

  localparam logic [1:0] REQ_NONE = 2'd0;
  localparam logic [1:0] REQ_RD   = 2'd1;
  localparam logic [1:0] REQ_WR   = 2'd2;
  localparam logic [1:0] EXP_NONE = 2'd0;
  localparam logic [1:0] EXP_UR   = 2'd1;
  localparam logic [1:0] EXP_ZERO = 2'd2;
  localparam logic [1:0] EXP_DATA = 2'd3;
  localparam int N_CASES = 9;
  localparam int N_CSR   = 6;
  localparam int WATCHDOG_TIME = (16 + (N_CASES + N_CSR) * 50) * 10;
  localparam logic [15:0] CPL_ID = 16'h0100;

  typedef struct packed {
    logic [95:0] name;
    logic [7:0]  fmt_type;     // {fmt, type}
    logic [9:0]  len;
    logic [3:0]  first_be;
    logic [3:0]  last_be;
    logic [15:0] req_id;
    logic [7:0]  tag;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [4:0]  resp_ladw;    // Memory response lower address
    logic [31:0] rddata;
    logic [1:0]  exp_req;
    logic [29:0] exp_dw_addr;
    logic [1:0]  exp_cpl;
    logic [11:0] exp_bc;
    logic [6:0]  exp_err;
  } case_t;

  logic        clk;
  logic        reset;
  logic [15:0] completer_id;
  logic        completer_id_valid;
  tlp_stream_t rx;
  logic        rx_ready;
  tlp_stream_t instant_tx;
  tlp_stream_t response_tx;
  mem_req_t    mem_req;
  logic        mem_req_valid;
  logic        mem_req_ready;
  mem_resp_t   mem_resp;
  logic        mem_resp_valid;
  logic        mem_resp_ready;
  logic        csr_read;
  logic [5:0]  csr_address;
  logic [31:0] csr_readdata;
  logic [6:0]  cpl_err;

  case_t       cases [N_CASES];
  case_t       cur;
  logic [95:0] cur_name;
  logic [6:0]  cur_lower;
  logic [31:0] exp_csr;
  logic        test_start;
  logic        test_done;
  logic        csr_check;
  int          tests_run;
  int          tests_failed;

  tb_clock u_clock (.clk(clk), .reset(reset));

  fejkon_tlp_top #(
    .REGION_ADDR_BITS (16),
    .STAT_WIDTH       (32)
  ) u_fejkon_tlp_top (
    .clk(clk), .reset(reset), .completer_id(completer_id),
    .completer_id_valid(completer_id_valid), .rx(rx), .rx_ready(rx_ready),
    .instant_tx(instant_tx), .response_tx(response_tx), .mem_req(mem_req),
    .mem_req_valid(mem_req_valid), .mem_req_ready(mem_req_ready), .mem_resp(mem_resp),
    .mem_resp_valid(mem_resp_valid), .mem_resp_ready(mem_resp_ready), .csr_read(csr_read),
    .csr_address(csr_address), .csr_readdata(csr_readdata), .cpl_err(cpl_err)
  );

  tlp_checker u_checker (
    .clk(clk), .reset(reset), .test_start(test_start), .test_done(test_done),
    .csr_check(csr_check), .test_name(cur_name), .exp_req(cur.exp_req),
    .exp_dw_addr(cur.exp_dw_addr), .exp_wdata(cur.wdata), .exp_req_id(cur.req_id),
    .exp_tag(cur.tag), .exp_cpl(cur.exp_cpl), .exp_bc(cur.exp_bc), .exp_lower(cur_lower),
    .exp_rddata(cur.rddata), .exp_err(cur.exp_err), .exp_csr(exp_csr),
    .completer_id(completer_id), .completer_id_valid(completer_id_valid),
    .rx_ready(rx_ready), .mem_resp_ready(mem_resp_ready),
    .mem_req(mem_req), .mem_req_valid(mem_req_valid),
    .instant_tx(instant_tx), .response_tx(response_tx), .cpl_err(cpl_err),
    .csr_readdata(csr_readdata), .tests_run(tests_run), .tests_failed(tests_failed)
  );

  // Lower address of a read completion comes from the response, else the request
  assign cur_lower = (cur.exp_cpl == EXP_DATA) ? {cur.resp_ladw, 2'b00}
                                               : {cur.addr[6:2], 2'b00};

  task automatic run_case(input case_t c);
    bit seen;
    @(posedge clk);
    #1;
    cur      = c;
    cur_name = c.name;
    rx       = '0;
    rx.data[0] = {c.fmt_type, 14'h0, c.len};
    rx.data[1] = {c.req_id, c.tag, c.last_be, c.first_be};
    rx.data[2] = c.addr;
    rx.data[3] = c.addr[2] ? c.wdata : ~c.wdata;  // Decoy in the unused slot
    rx.data[4] = c.addr[2] ? ~c.wdata : c.wdata;
    rx.empty   = c.fmt_type[6] ? (c.addr[2] ? 3'd4 : 3'd3) : 3'd5;
    rx.valid         = 1'b1;
    rx.startofpacket = 1'b1;
    rx.endofpacket   = 1'b1;
    test_start = 1'b1;
    @(posedge clk);
    #1;
    rx         = '0;
    test_start = 1'b0;
    seen       = 1'b0;
    for (int k = 0; k < 10 && !seen; k++) begin
      @(posedge clk);
      #1;
      seen = mem_req_valid || instant_tx.valid;
    end
    if (c.exp_cpl == EXP_DATA && mem_req_valid) begin
      mem_resp.requester_id = c.req_id;  // Memory side echoes ID and tag
      mem_resp.tag          = c.tag;
      mem_resp.lower_addr_dw = c.resp_ladw;
      mem_resp.rddata       = c.rddata;
      mem_resp_valid        = 1'b1;
      @(posedge clk);
      #1;
      mem_resp_valid = 1'b0;
      seen = response_tx.valid;
      for (int k = 0; k < 10 && !seen; k++) begin
        @(posedge clk);
        #1;
        seen = response_tx.valid;
      end
    end
    repeat (2) @(posedge clk);
    #1 test_done = 1'b1;
    @(posedge clk);
    #1 test_done = 1'b0;
  endtask

  task automatic read_csr(input logic [5:0] addr, input logic [31:0] expv,
                          input logic [95:0] name);
    @(posedge clk);
    #1;
    csr_read    = 1'b1;
    csr_address = addr;
    exp_csr     = expv;
    cur_name    = name;
    @(posedge clk);
    #1;
    csr_read  = 1'b0;
    csr_check = 1'b1;
    @(posedge clk);
    #1 csr_check = 1'b0;
  endtask

  initial begin
    #(WATCHDOG_TIME);
    $display("watchdog: the run did not finish in the allotted time");
    $display("Simulation failed");
    $finish;
  end

  initial begin
    int n_unsup;
    int n_inst;
    int n_resp;
    completer_id       = CPL_ID;
    completer_id_valid = 1'b1;
    rx                 = '0;
    mem_req_ready      = 1'b1;
    mem_resp           = '0;
    mem_resp_valid     = 1'b0;
    csr_read           = 1'b0;
    csr_address        = 6'd0;
    exp_csr            = 32'h0;
    test_start         = 1'b0;
    test_done          = 1'b0;
    csr_check          = 1'b0;
    cur                = '0;
    cur_name           = '0;
    // name, fmt_type, len, fbe, lbe, req_id, tag, addr, wdata, ladw, rddata,
    // exp_req, exp_dw_addr, exp_cpl, exp_bc, exp_err
    cases[0] = '{"mwr_a0", 8'h40, 10'd1, 4'hf, 4'h0, 16'h0a01, 8'h01, 32'h1234_5670,
                 32'hdead_beef, 5'd0, 32'h0, REQ_WR, 30'h159c, EXP_NONE, 12'd0, 7'h00};
    cases[1] = '{"mwr_a4", 8'h40, 10'd1, 4'hf, 4'h0, 16'h0a01, 8'h02, 32'habcd_0124,
                 32'h0bad_f00d, 5'd0, 32'h0, REQ_WR, 30'h0049, EXP_NONE, 12'd0, 7'h00};
    cases[2] = '{"mrd_even", 8'h00, 10'd1, 4'hf, 4'h0, 16'h0a02, 8'h11, 32'h0000_2008,
                 32'h0, 5'h02, 32'hcafe_f00d, REQ_RD, 30'h0802, EXP_DATA, 12'd4, 7'h00};
    cases[3] = '{"mrd_odd", 8'h00, 10'd1, 4'hf, 4'h0, 16'h0a03, 8'h12, 32'h0001_300c,
                 32'h0, 5'h03, 32'h1357_9bdf, REQ_RD, 30'h0c03, EXP_DATA, 12'd4, 7'h00};
    cases[4] = '{"mrd_len2", 8'h00, 10'd2, 4'hf, 4'hf, 16'h0a04, 8'h13, 32'h0000_0040,
                 32'h0, 5'd0, 32'h0, REQ_NONE, 30'h0, EXP_UR, 12'd8, 7'h20};
    cases[5] = '{"mrd_be3", 8'h00, 10'd1, 4'h3, 4'h0, 16'h0a05, 8'h14, 32'h0000_0044,
                 32'h0, 5'd0, 32'h0, REQ_NONE, 30'h0, EXP_UR, 12'd2, 7'h20};
    cases[6] = '{"mwr_len2", 8'h40, 10'd2, 4'hf, 4'hf, 16'h0a06, 8'h15, 32'h0000_0080,
                 32'h5555_aaaa, 5'd0, 32'h0, REQ_NONE, 30'h0, EXP_NONE, 12'd0, 7'h10};
    // Locked read is non-posted, so it is answered with UR
    cases[7] = '{"mrdlk", 8'h01, 10'd1, 4'hf, 4'h0, 16'h0a07, 8'h16, 32'h0000_008c,
                 32'h0, 5'd0, 32'h0, REQ_NONE, 30'h0, EXP_UR, 12'd4, 7'h20};
    cases[8] = '{"mrd_zero", 8'h00, 10'd1, 4'h0, 4'h0, 16'h0a08, 8'h17, 32'h0000_0090,
                 32'h0, 5'd0, 32'h0, REQ_NONE, 30'h0, EXP_ZERO, 12'd0, 7'h00};
    @(negedge reset);
    n_unsup = 0;
    n_inst  = 0;
    n_resp  = 0;
    for (int i = 0; i < N_CASES; i++) begin
      run_case(cases[i]);
      if (cases[i].exp_err != 7'h0) n_unsup++;
      if (cases[i].exp_cpl == EXP_UR || cases[i].exp_cpl == EXP_ZERO) n_inst++;
      if (cases[i].exp_cpl == EXP_DATA) n_resp++;
    end
    cur = '0;
    read_csr(6'd0, {15'h0, 1'b1, CPL_ID}, "csr_status");
    completer_id_valid = 1'b0;  // Ready outputs drop with the ID
    read_csr(6'd1, 32'(N_CASES), "csr_rx");
    read_csr(6'd2, 32'(n_unsup), "csr_unsup");
    read_csr(6'd4, 32'(n_inst), "csr_instant");
    read_csr(6'd5, 32'(n_resp), "csr_resp");
    read_csr(6'd9, 32'hffff_ffff, "csr_unmapped");
    repeat (2) @(posedge clk);
    $display("%0d tests run, %0d failed", tests_run, tests_failed);
    if (tests_failed == 0 && tests_run == N_CASES + N_CSR) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sources.f
hdl/tlp_pkg.sv
hdl/tlp_rx_decoder.sv
hdl/tlp_request_router.sv
hdl/completion_builder.sv
hdl/tlp_stats_csr.sv
hdl/fejkon_tlp_top.sv
tests/tb_clock.sv
tests/tlp_checker.sv
tests/tb_top.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it, and look for the pass message.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_top -f sources.f -o tb_sim \
  && ./obj_dir/tb_sim | tee /dev/stderr | grep -q "Simulation completed successfully" \
  && echo "run_sim: PASS" && exit 0 \
  || { echo "run_sim: FAIL"; exit 1; }
